//--- sim.f
+incdir+logic
logic/kcpu_pkg.sv
logic/kcpu_stack_ram.sv
logic/kcpu_stack_seq.sv
logic/kcpu_regs.sv
logic/kcpu_reg_unit.sv
tests/kcpu_reg_unit_tb.sv

//--- Makefile
# Verilator build and run of the register block testbench

VERILATOR ?= verilator
TOP       ?= kcpu_reg_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "test FAILED, no pass line in $(LOG)"; exit 1; }
	@echo "test PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/kcpu_reg_unit_tb.sv
/* Table-driven testbench for the register block, checked against a behavioral model.
   Rows run one at a time and stack rows wait for busy to fall.
   Each pull row expects the matching push row earlier in the table. */

`default_nettype none

`include "kcpu_consts.svh"

module kcpu_reg_unit_tb
    import kcpu_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int RST_CYCLES     = 5;
localparam int CYCLES_PER_ROW = 20;

logic      clk;
logic      rst;
logic      start;
logic      stack_u;
reg_cmd_e  cmd;
byte_t     post;
word_t     data;
word_t     pc;
logic      busy;
logic      pc_load;
word_t     new_pc, ea, x, y, u, s;
byte_t     a, b, dp, cc;

// stimulus table, one entry per row in each queue
reg_cmd_e  q_cmd[$];
byte_t     q_post[$];
word_t     q_data[$];
logic      q_stack_u[$];
word_t     q_pc[$];
string     q_name[$];

// model state
byte_t     m_a, m_b, m_dp, m_cc;
word_t     m_x, m_y, m_u, m_s, m_new_pc;
byte_t     m_mem [`KCPU_STACK_DEPTH];
word_t     exp_ea;
int        exp_busy;
logic      exp_pc_load;

int        error_count = 0;
int        cycle_count = 0;
int        cycle_limit = 0;

kcpu_reg_unit u_dut (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .cmd     (cmd),
    .post    (post),
    .data    (data),
    .stack_u (stack_u),
    .pc      (pc),
    .busy    (busy),
    .pc_load (pc_load),
    .new_pc  (new_pc),
    .ea      (ea),
    .a       (a),
    .b       (b),
    .dp      (dp),
    .cc      (cc),
    .x       (x),
    .y       (y),
    .u       (u),
    .s       (s)
);

always #50 clk = ~clk;

always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
        $display("timeout after %0d cycles, a command never completed", cycle_count);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end
end

function automatic word_t rand_word();
    return word_t'($urandom);
endfunction

task automatic add_row(input reg_cmd_e c, input byte_t p, input word_t d, input logic su,
                       input word_t pcv, input string name);
    q_cmd.push_back(c);
    q_post.push_back(p);
    q_data.push_back(d);
    q_stack_u.push_back(su);
    q_pc.push_back(pcv);
    q_name.push_back(name);
endtask

task automatic add_load(input logic [2:0] code, input word_t value, input string name);
    add_row(cmd_load, {5'b00000, code}, value, 1'b0, 16'h0000, name);
endtask

task automatic build_table();
    byte_t cc_posts [8] = '{8'h81, 8'h01, 8'h82, 8'h02, 8'h84, 8'h04, 8'h87, 8'h07};
    for (int code = 0; code < 8; code++)
        add_load(3'(code), rand_word(), $sformatf("load_r%0d", code));
    for (int dst = 0; dst < 6; dst++) begin
        for (int src = 0; src < 6; src++) begin
            add_load(3'(src), rand_word(), "tfr_prep");
            add_row(cmd_tfr, {1'b0, 3'(src), 1'b0, 3'(dst)}, 16'h0000, 1'b0, 16'h0000,
                    $sformatf("tfr_%0d_from_%0d", dst, src));
            add_load(3'(dst), rand_word(), "exg_prep");
            add_row(cmd_exg, {1'b0, 3'(src), 1'b0, 3'(dst)}, 16'h0000, 1'b0, 16'h0000,
                    $sformatf("exg_%0d_with_%0d", dst, src));
        end
    end
    add_row(cmd_tfr, 8'h60, 16'h0000, 1'b0, 16'h0000, "tfr_bad_src");
    add_row(cmd_tfr, 8'h17, 16'h0000, 1'b0, 16'h0000, "tfr_bad_dst");
    add_row(cmd_exg, 8'h70, 16'h0000, 1'b0, 16'h0000, "exg_bad_src");
    add_row(cmd_exg, 8'h26, 16'h0000, 1'b0, 16'h0000, "exg_bad_dst");
    // mode bit 1 is post-increment, bit 0 a step of two
    for (int code = 2; code < 6; code++) begin
        add_load(3'(code), rand_word(), "idx_prep");
        for (int mode = 0; mode < 4; mode++)
            add_row(cmd_idx, {3'b000, 2'(mode), 3'(code)}, 16'h0000, 1'b0, 16'h0000,
                    $sformatf("idx_r%0d_mode%0d", code, mode));
    end
    for (int code = 0; code < 8; code++)
        add_load(3'(code), rand_word(), "push_s_prep");
    add_row(cmd_push, 8'h7f, 16'h0000, 1'b0, 16'h0000, "push_s");
    for (int code = 0; code < 8; code++)
        if (3'(code) != `KCPU_REG_S)
            add_load(3'(code), 16'h0000, "push_s_clear");
    add_row(cmd_pull, 8'h7f, 16'h0000, 1'b0, 16'h0000, "pull_s");
    for (int code = 0; code < 8; code++)
        add_load(3'(code), rand_word(), "push_u_prep");
    add_row(cmd_push, 8'hff, 16'h0000, 1'b1, rand_word(), "push_u");   // saves s and pc
    for (int code = 0; code < 8; code++)
        if (3'(code) != `KCPU_REG_U)
            add_load(3'(code), 16'h0000, "push_u_clear");
    add_row(cmd_pull, 8'hff, 16'h0000, 1'b1, 16'h0000, "pull_u");
    add_load(3'd7, rand_word(), "cc_prep");
    foreach (cc_posts[k])
        add_row(cmd_cc, cc_posts[k], 16'h0000, 1'b0, 16'h0000, $sformatf("cc_%02h", cc_posts[k]));
endtask

function automatic word_t model_get(input logic [2:0] code);
    case (code)
        `KCPU_REG_A:  return {8'h00, m_a};
        `KCPU_REG_B:  return {8'h00, m_b};
        `KCPU_REG_X:  return m_x;
        `KCPU_REG_Y:  return m_y;
        `KCPU_REG_S:  return m_s;
        `KCPU_REG_U:  return m_u;
        `KCPU_REG_DP: return {8'h00, m_dp};
        default:      return {8'h00, m_cc};
    endcase
endfunction

task automatic model_set(input logic [2:0] code, input word_t v);
    case (code)
        `KCPU_REG_A:  m_a  = v[7:0];   // 8 bit targets keep the low byte
        `KCPU_REG_B:  m_b  = v[7:0];
        `KCPU_REG_X:  m_x  = v;
        `KCPU_REG_Y:  m_y  = v;
        `KCPU_REG_S:  m_s  = v;
        `KCPU_REG_U:  m_u  = v;
        `KCPU_REG_DP: m_dp = v[7:0];
        default:      m_cc = v[7:0];
    endcase
endtask

// register behind one mask bit at push time
function automatic word_t stack_value(input int bit_i, input logic on_u, input word_t pcv);
    case (bit_i)
        7:       return pcv;
        6:       return on_u ? m_s : m_u;
        5:       return m_y;
        4:       return m_x;
        3:       return {8'h00, m_dp};
        2:       return {8'h00, m_b};
        1:       return {8'h00, m_a};
        default: return {8'h00, m_cc};
    endcase
endfunction

task automatic model_push(input reg_mask_t mask, input logic on_u, input word_t pcv);
    word_t sp;
    word_t v;
    sp = on_u ? m_u : m_s;
    for (int bit_i = 7; bit_i >= 0; bit_i--) begin
        if (mask[bit_i]) begin
            v  = stack_value(bit_i, on_u, pcv);
            sp = sp - 16'd1;
            m_mem[sp[7:0]] = v[7:0];
            exp_busy++;
            if (bit_i >= 4) begin
                sp = sp - 16'd1;
                m_mem[sp[7:0]] = v[15:8];   // high byte ends up at the lower address
                exp_busy++;
            end
        end
    end
    if (on_u)
        m_u = sp;
    else
        m_s = sp;
endtask

task automatic model_pull(input reg_mask_t mask, input logic on_u);
    word_t sp;
    word_t v;
    sp = on_u ? m_u : m_s;
    for (int bit_i = 0; bit_i < 8; bit_i++) begin
        if (mask[bit_i]) begin
            v  = {8'h00, m_mem[sp[7:0]]};
            sp = sp + 16'd1;
            exp_busy++;
            if (bit_i >= 4) begin
                v  = {v[7:0], m_mem[sp[7:0]]};
                sp = sp + 16'd1;
                exp_busy++;
            end
            case (bit_i)
                7: begin
                    m_new_pc    = v;
                    exp_pc_load = 1'b1;
                end
                6: begin
                    if (on_u)
                        m_s = v;
                    else
                        m_u = v;
                end
                5:       m_y  = v;
                4:       m_x  = v;
                3:       m_dp = v[7:0];
                2:       m_b  = v[7:0];
                1:       m_a  = v[7:0];
                default: m_cc = v[7:0];
            endcase
        end
    end
    if (on_u)
        m_u = sp;
    else
        m_s = sp;
endtask

task automatic model_apply(input int i);
    byte_t p;
    word_t src_v, dst_v, old_v, step;
    p           = q_post[i];
    exp_busy    = 0;
    exp_pc_load = 1'b0;
    case (q_cmd[i])
        cmd_load: model_set(p[2:0], q_data[i]);
        cmd_tfr, cmd_exg: begin
            if (p[6:4] <= `KCPU_REG_U && p[2:0] <= `KCPU_REG_U) begin
                src_v = model_get(p[6:4]);
                dst_v = model_get(p[2:0]);
                model_set(p[2:0], src_v);
                if (q_cmd[i] == cmd_exg)
                    model_set(p[6:4], dst_v);
            end
        end
        cmd_idx: begin
            old_v  = model_get(p[2:0]);
            step   = p[3] ? 16'd2 : 16'd1;
            exp_ea = p[4] ? old_v : old_v - step;
            model_set(p[2:0], p[4] ? old_v + step : old_v - step);
        end
        cmd_cc: begin
            if (p[0])
                m_cc[`KCPU_CC_E] = p[7];
            if (p[1])
                m_cc[`KCPU_CC_I] = p[7];
            if (p[2])
                m_cc[`KCPU_CC_F] = p[7];
        end
        cmd_push: model_push(p, q_stack_u[i], q_pc[i]);
        cmd_pull: model_pull(p, q_stack_u[i]);
        default: ;
    endcase
endtask

task automatic check_val(input string name, input string what, input word_t exp_v,
                         input word_t act_v);
    assert (act_v === exp_v) else begin
        error_count++;
        $display("ERROR %s: %s expected %h actual %h", name, what, exp_v, act_v);
        $display("Simulation failed");
        $fatal(1, "mismatch in %s", name);
    end
endtask

task automatic check_regs(input string name);
    check_val(name, "a", {8'h00, m_a}, {8'h00, a});
    check_val(name, "b", {8'h00, m_b}, {8'h00, b});
    check_val(name, "dp", {8'h00, m_dp}, {8'h00, dp});
    check_val(name, "cc", {8'h00, m_cc}, {8'h00, cc});
    check_val(name, "x", m_x, x);
    check_val(name, "y", m_y, y);
    check_val(name, "u", m_u, u);
    check_val(name, "s", m_s, s);
    check_val(name, "new_pc", m_new_pc, new_pc);
endtask

initial begin
    int busy_cycles;
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    cmd      = cmd_nop;
    post     = '0;
    data     = '0;
    stack_u  = 1'b0;
    pc       = '0;
    m_a      = '0;
    m_b      = '0;
    m_dp     = '0;
    m_cc     = '0;
    m_x      = '0;
    m_y      = '0;
    m_u      = '0;
    m_s      = '0;
    m_new_pc = '0;
    exp_ea   = '0;
    void'($urandom(32'hd13f_84f6));
    build_table();
    cycle_limit = CYCLES_PER_ROW * q_cmd.size() + RST_CYCLES;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_regs("reset");
    check_val("reset", "busy", 16'h0000, {15'd0, busy});
    check_val("reset", "pc_load", 16'h0000, {15'd0, pc_load});
    for (int i = 0; i < q_cmd.size(); i++) begin
        cmd     = q_cmd[i];
        post    = q_post[i];
        data    = q_data[i];
        stack_u = q_stack_u[i];
        pc      = q_pc[i];     // held through the push, the byte mux reads it late
        start   = 1'b1;
        model_apply(i);
        if (q_cmd[i] == cmd_idx) begin
            #10;
            check_val(q_name[i], "ea", exp_ea, ea);
        end
        @(negedge clk);
        start = 1'b0;
        cmd   = cmd_nop;
        busy_cycles = 0;
        while (busy) begin
            busy_cycles++;
            @(negedge clk);
        end
        check_val(q_name[i], "busy cycles", word_t'(exp_busy), word_t'(busy_cycles));
        check_val(q_name[i], "pc_load", {15'd0, exp_pc_load}, {15'd0, pc_load});
        check_regs(q_name[i]);
        @(negedge clk);
        check_val(q_name[i], "pc_load one cycle later", 16'h0000, {15'd0, pc_load});
    end
    if (error_count == 0) begin
        $display("Simulation passed");
        $finish;
    end else begin
        $display("Simulation failed");
        $fatal(1, "%0d checks failed", error_count);
    end
end

endmodule

`default_nettype wire

//--- logic/kcpu_reg_unit.sv
/* Register block top. Commands start on a one-cycle start pulse.
   Wait for busy low before the next start; start during busy is ignored.
   new_pc is valid while pc_load is high after a pull with mask bit 7. */

`default_nettype none

module kcpu_reg_unit
    import kcpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             start,
    input  wire reg_cmd_e   cmd,
    input  wire byte_t      post,
    input  wire word_t      data,
    input  wire             stack_u,
    input  wire word_t      pc,
    output logic            busy,
    output logic            pc_load,
    output word_t           new_pc,
    output word_t           ea,
    output byte_t           a,
    output byte_t           b,
    output byte_t           dp,
    output byte_t           cc,
    output word_t           x,
    output word_t           y,
    output word_t           u,
    output word_t           s
);

reg_mask_t  psh_sel, stack_bit;
logic       psh_hihalf, psh_dec, pul_en, wr_en;
byte_t      psh_mux, psh_addr, mdata;

kcpu_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd        (cmd),
    .post       (post),
    .data       (data),
    .pc         (pc),
    .stack_u    (stack_u),
    .psh_sel    (psh_sel),
    .psh_hihalf (psh_hihalf),
    .psh_dec    (psh_dec),
    .pul_en     (pul_en),
    .stack_busy (busy),
    .mdata      (mdata),
    .stack_bit  (stack_bit),
    .psh_mux    (psh_mux),
    .psh_addr   (psh_addr),
    .ea         (ea),
    .new_pc     (new_pc),
    .a          (a),
    .b          (b),
    .dp         (dp),
    .cc         (cc),
    .x          (x),
    .y          (y),
    .u          (u),
    .s          (s)
);

kcpu_stack_seq u_seq (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd        (cmd),
    .post       (post),
    .stack_bit  (stack_bit),
    .psh_sel    (psh_sel),
    .psh_hihalf (psh_hihalf),
    .psh_dec    (psh_dec),
    .pul_en     (pul_en),
    .stack_busy (busy),
    .wr_en      (wr_en),
    .pc_load    (pc_load)
);

// one address serves both ports since it tracks the active pointer
kcpu_stack_ram u_ram (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_addr    (psh_addr),
    .rd_addr    (psh_addr),
    .wr_data    (psh_mux),
    .rd_data    (mdata)
);

endmodule

`default_nettype wire

//--- logic/kcpu_regs.sv
/* Register set A, B, DP, CC, X, Y, U, S of the core and the stack data path.
   tfr writes the register coded in post[2:0] with the one coded in post[6:4].
   An 8 bit source reaches a 16 bit register zero extended.
   cc takes a one-hot select in post[2:0] (bit 0 E, bit 1 I, bit 2 F) and post[7] as value.
   Commands other than push/pull are ignored while the stack is busy. */

`default_nettype none

`include "kcpu_consts.svh"

module kcpu_regs
    import kcpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             start,
    input  wire reg_cmd_e   cmd,
    input  wire byte_t      post,
    input  wire word_t      data,
    input  wire word_t      pc,
    input  wire             stack_u,
    // stack sequencer
    input  wire reg_mask_t  psh_sel,
    input  wire             psh_hihalf,
    input  wire             psh_dec,
    input  wire             pul_en,
    input  wire             stack_busy,
    input  wire byte_t      mdata,
    output reg_mask_t       stack_bit,
    output byte_t           psh_mux,
    output byte_t           psh_addr,
    // results
    output word_t           ea,
    output word_t           new_pc,
    output byte_t           a,
    output byte_t           b,
    output byte_t           dp,
    output byte_t           cc,
    output word_t           x,
    output word_t           y,
    output word_t           u,
    output word_t           s
);

logic   go;
logic   use_u, nx_use_u;        // stack in use by push/pull
logic   tfr_ok, idx_ok;
word_t  src_val, dst_val;
word_t  idx_old, idx_step, idx_new;
word_t  sp_other;
byte_t  psh_byte;
byte_t  nx_a, nx_b, nx_dp, nx_cc;
word_t  nx_x, nx_y, nx_u, nx_s, nx_pc;

function automatic word_t reg_read(input logic [2:0] code);
    word_t val;
    case (code)
        `KCPU_REG_A: val = {8'h00, a};
        `KCPU_REG_B: val = {8'h00, b};
        `KCPU_REG_X: val = x;
        `KCPU_REG_Y: val = y;
        `KCPU_REG_S: val = s;
        `KCPU_REG_U: val = u;
        default:     val = '0;
    endcase
    return val;
endfunction

function automatic byte_t pick_byte(input word_t w, input logic hi);
    return hi ? w[15:8] : w[7:0];
endfunction

function automatic word_t put_byte(input word_t w, input logic hi, input byte_t v);
    word_t r;
    r = w;
    if (hi)
        r[15:8] = v;
    else
        r[7:0] = v;
    return r;
endfunction

assign go       = start && !stack_busy;
assign sp_other = use_u ? s : u;
assign nx_use_u = (go && (cmd == cmd_push || cmd == cmd_pull)) ? stack_u : use_u;

// operand decode for tfr/exg and indexed mode
always_comb begin
    src_val  = reg_read(post[6:4]);
    dst_val  = reg_read(post[2:0]);
    tfr_ok   = post[2:0] <= `KCPU_REG_U && post[6:4] <= `KCPU_REG_U;
    idx_ok   = post[2:0] inside {`KCPU_REG_X, `KCPU_REG_Y, `KCPU_REG_S, `KCPU_REG_U};
    idx_old  = idx_ok ? dst_val : '0;   // index register sits in the low field
    idx_step = post[3] ? 16'd2 : 16'd1;
    ea       = post[4] ? idx_old : idx_old - idx_step;   // pre-decrement returns new value
    idx_new  = post[4] ? idx_old + idx_step : ea;
end

// pull takes the lowest pending bit, push the highest
always_comb begin
    stack_bit = '0;
    if (pul_en) begin
        stack_bit = psh_sel & (~psh_sel + 8'd1);
    end else begin
        for (int i = 0; i < 8; i++) begin
            if (psh_sel[i])
                stack_bit = reg_mask_t'(8'h01 << i);
        end
    end
end

always_comb begin
    case (stack_bit)
        8'h80:   psh_byte = pick_byte(pc, psh_hihalf);
        8'h40:   psh_byte = pick_byte(sp_other, psh_hihalf);
        8'h20:   psh_byte = pick_byte(y, psh_hihalf);
        8'h10:   psh_byte = pick_byte(x, psh_hihalf);
        8'h08:   psh_byte = dp;
        8'h04:   psh_byte = b;
        8'h02:   psh_byte = a;
        8'h01:   psh_byte = cc;
        default: psh_byte = '0;
    endcase
end

always_comb begin
    nx_a  = a;
    nx_b  = b;
    nx_dp = dp;
    nx_cc = cc;
    nx_x  = x;
    nx_y  = y;
    nx_u  = u;
    nx_s  = s;
    nx_pc = new_pc;
    if (go) begin
        case (cmd)
            cmd_load: begin
                case (post[2:0])
                    `KCPU_REG_A:  nx_a  = data[7:0];
                    `KCPU_REG_B:  nx_b  = data[7:0];
                    `KCPU_REG_X:  nx_x  = data;
                    `KCPU_REG_Y:  nx_y  = data;
                    `KCPU_REG_S:  nx_s  = data;
                    `KCPU_REG_U:  nx_u  = data;
                    `KCPU_REG_DP: nx_dp = data[7:0];
                    default:      nx_cc = data[7:0];
                endcase
            end
            cmd_tfr, cmd_exg: begin
                if (tfr_ok) begin
                    case (post[2:0])
                        `KCPU_REG_A: nx_a = src_val[7:0];   // low byte only
                        `KCPU_REG_B: nx_b = src_val[7:0];
                        `KCPU_REG_X: nx_x = src_val;
                        `KCPU_REG_Y: nx_y = src_val;
                        `KCPU_REG_S: nx_s = src_val;
                        default:     nx_u = src_val;
                    endcase
                    if (cmd == cmd_exg) begin
                        case (post[6:4])
                            `KCPU_REG_A: nx_a = dst_val[7:0];
                            `KCPU_REG_B: nx_b = dst_val[7:0];
                            `KCPU_REG_X: nx_x = dst_val;
                            `KCPU_REG_Y: nx_y = dst_val;
                            `KCPU_REG_S: nx_s = dst_val;
                            default:     nx_u = dst_val;
                        endcase
                    end
                end
            end
            cmd_idx: begin
                case (post[2:0])
                    `KCPU_REG_X: nx_x = idx_new;
                    `KCPU_REG_Y: nx_y = idx_new;
                    `KCPU_REG_S: nx_s = idx_new;
                    `KCPU_REG_U: nx_u = idx_new;
                    default: ;  // no index register, nothing moves
                endcase
            end
            cmd_cc: begin
                if (post[0]) nx_cc[`KCPU_CC_E] = post[7];
                if (post[1]) nx_cc[`KCPU_CC_I] = post[7];
                if (post[2]) nx_cc[`KCPU_CC_F] = post[7];
            end
            default: ;
        endcase
    end
    // push pre-decrements, pull post-increments the active pointer
    if (psh_dec) begin
        if (use_u)
            nx_u = u - 16'd1;
        else
            nx_s = s - 16'd1;
    end
    if (pul_en) begin
        if (use_u)
            nx_u = u + 16'd1;
        else
            nx_s = s + 16'd1;
        case (stack_bit)
            8'h80: nx_pc = put_byte(new_pc, psh_hihalf, mdata);
            8'h40: begin
                if (use_u)
                    nx_s = put_byte(s, psh_hihalf, mdata);
                else
                    nx_u = put_byte(u, psh_hihalf, mdata);
            end
            8'h20: nx_y  = put_byte(y, psh_hihalf, mdata);
            8'h10: nx_x  = put_byte(x, psh_hihalf, mdata);
            8'h08: nx_dp = mdata;
            8'h04: nx_b  = mdata;
            8'h02: nx_a  = mdata;
            8'h01: nx_cc = mdata;
            default: ;
        endcase
    end
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        a      <= '0;
        b      <= '0;
        dp     <= '0;
        cc     <= '0;
        x      <= '0;
        y      <= '0;
        u      <= '0;
        s      <= '0;
        new_pc <= '0;
        use_u  <= 1'b0;
    end else begin
        a      <= nx_a;
        b      <= nx_b;
        dp     <= nx_dp;
        cc     <= nx_cc;
        x      <= nx_x;
        y      <= nx_y;
        u      <= nx_u;
        s      <= nx_s;
        new_pc <= nx_pc;
        use_u  <= nx_use_u;
    end
end

// psh_addr follows the active pointer, so it is both write and read address
always_ff @(posedge clk) begin
    psh_mux  <= psh_byte;
    psh_addr <= nx_use_u ? nx_u[7:0] : nx_s[7:0];
end

tfr_bad_code_no_change: assert property (@(posedge clk) disable iff (rst)
    go && (cmd == cmd_tfr || cmd == cmd_exg) && !tfr_ok
        |=> $stable({a, b, dp, cc, x, y, u, s}))
    else $error("tfr/exg with invalid code changed a register");

endmodule

`default_nettype wire

//--- logic/kcpu_stack_seq.sv
/* Push/pull sequencer. One byte per cycle, 16 bit registers take two.
   Push walks the mask from bit 7 down, pull from bit 0 up.
   A zero mask is accepted but never raises busy. */

`default_nettype none

module kcpu_stack_seq
    import kcpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             start,
    input  wire reg_cmd_e   cmd,
    input  wire reg_mask_t  post,
    input  wire reg_mask_t  stack_bit,   // register served this cycle
    output reg_mask_t       psh_sel,
    output logic            psh_hihalf,
    output logic            psh_dec,
    output logic            pul_en,
    output logic            stack_busy,
    output logic            wr_en,
    output logic            pc_load
);

seq_state_e state;
reg_mask_t  mask;
reg_mask_t  rest;
logic       half;       // first byte of a 16 bit register done
logic       wide;

assign psh_sel    = mask;
assign psh_dec    = state == seq_push;
assign pul_en     = state == seq_pull;
assign stack_busy = state != seq_idle;
assign psh_hihalf = pul_en ? ~half : half;  // pull gets the high byte first
assign wide       = |stack_bit[7:4];
assign rest       = mask & ~stack_bit;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        state   <= seq_idle;
        mask    <= '0;
        half    <= 1'b0;
        wr_en   <= 1'b0;
        pc_load <= 1'b0;
    end else begin
        wr_en   <= psh_dec;     // byte and address are registered in the regs block
        pc_load <= 1'b0;
        case (state)
            seq_idle: begin
                half <= 1'b0;
                if (start && post != '0) begin
                    case (cmd)
                        cmd_push: begin
                            mask  <= post;
                            state <= seq_push;
                        end
                        cmd_pull: begin
                            mask  <= post;
                            state <= seq_pull;
                        end
                        default: ;
                    endcase
                end
            end
            default: begin
                if (wide && !half) begin
                    half <= 1'b1;
                end else begin
                    half <= 1'b0;
                    mask <= rest;
                    if (rest == '0) begin
                        state   <= seq_idle;
                        pc_load <= pul_en && stack_bit[7];  // pc is always the last pull
                    end
                end
            end
        endcase
    end
end

busy_has_mask: assert property (@(posedge clk) disable iff (rst)
    stack_busy |-> mask != '0)
    else $error("stack sequencer busy with an empty mask");

no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
    stack_busy |-> !start)
    else $error("start asserted while the stack is busy");

endmodule

`default_nettype wire

//--- logic/kcpu_stack_ram.sv
/* Stack memory. Synchronous write, read without a clock.
   Contents are not cleared by reset. */

`default_nettype none

`include "kcpu_consts.svh"

module kcpu_stack_ram
    import kcpu_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         wr_en,
    input  wire byte_t  wr_addr,
    input  wire byte_t  rd_addr,
    input  wire byte_t  wr_data,
    output byte_t       rd_data
);

byte_t mem [`KCPU_STACK_DEPTH];

always_ff @(posedge clk) begin
    if (wr_en)
        mem[wr_addr] <= wr_data;
end

assign rd_data = mem[rd_addr];  // same cycle read for pull

wr_en_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(wr_en))
    else $error("stack ram write enable is unknown");

endmodule

`default_nettype wire

//--- logic/kcpu_pkg.sv
/* Shared types of the register block.
   Every width is fixed by the instruction set. */

`default_nettype none

package kcpu_pkg;

    // 8 bit registers, stack bytes and post bytes
    typedef logic [7:0] byte_t;

    // index registers, stack pointers, addresses
    typedef logic [15:0] word_t;

    // push/pull mask
    // bit 7 pc, 6 other stack pointer, 5 y, 4 x, 3 dp, 2 b, 1 a, 0 cc
    typedef logic [7:0] reg_mask_t;

    // command port encoding
    typedef enum logic [2:0] {
        cmd_nop  = 3'd0,
        cmd_load = 3'd1,
        cmd_tfr  = 3'd2,
        cmd_exg  = 3'd3,
        cmd_idx  = 3'd4,
        cmd_cc   = 3'd5,
        cmd_push = 3'd6,
        cmd_pull = 3'd7
    } reg_cmd_e;

    // stack sequencer states
    typedef enum logic [1:0] {
        seq_idle = 2'd0,
        seq_push = 2'd1,
        seq_pull = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

//--- logic/kcpu_consts.svh
/* Register codes, CC bit positions and stack size for the register block.
   Codes 0 to 5 are the only valid tfr/exg/idx selectors.
   Codes 6 and 7 select DP and CC and are only meaningful for a load. */

`ifndef KCPU_CONSTS_SVH
`define KCPU_CONSTS_SVH

// register codes carried in the post byte fields
`define KCPU_REG_A   3'd0
`define KCPU_REG_B   3'd1
`define KCPU_REG_X   3'd2
`define KCPU_REG_Y   3'd3
`define KCPU_REG_S   3'd4
`define KCPU_REG_U   3'd5
`define KCPU_REG_DP  3'd6   // load only
`define KCPU_REG_CC  3'd7   // load only

// bit positions inside CC
`define KCPU_CC_E    7      // entire state saved
`define KCPU_CC_F    6      // firq mask
`define KCPU_CC_I    4      // irq mask

// stack memory size in bytes
// indexed by the low byte of the stack pointer
`define KCPU_STACK_DEPTH 256

`endif
